//--- Bender.yml
package:
  name: bht_predictor

sources:
  # synthesizable predictor, package and interfaces first
  - files:
      - design/bht_pkg.sv
      - design/bht_lookup_if.sv
      - design/bht_train_if.sv
      - design/bht_tables.sv
      - design/bht_lookup.sv
      - design/bht_train.sv
      - design/bht_predictor_top.sv

  # testbench, bound properties and clock source
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/bht_predictor_properties.sv
      - tb/tb_bht_predictor.sv

//--- design/bht_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module bht_lookup (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic [bht_pkg::fetch_width-1:0][bht_pkg::pc_width-1:0] fetch_pc,
    output logic [bht_pkg::fetch_width-1:0]                         taken,
    bht_lookup_if.lookup                                            lk
);

    logic [bht_pkg::fetch_width-1:0] taken_next;

    // index bits of each fetch address go straight to the tables
    always_comb begin
        for (int s = 0; s < bht_pkg::fetch_width; s++) begin
            lk.rd_index[s] = fetch_pc[s][bht_pkg::index_hi:bht_pkg::index_lo];
        end
    end

    // guess per slot from the counter state
    always_comb begin
        for (int s = 0; s < bht_pkg::fetch_width; s++) begin
            taken_next[s] = (lk.rd_counter[s] == bht_pkg::weak_taken) ||
                            (lk.rd_counter[s] == bht_pkg::strong_taken);
        end
    end

    // one cycle from fetch to guess
    always_ff @(posedge clk) begin
        if (rst) begin
            taken <= '0;
        end else begin
            taken <= taken_next;
        end
    end

endmodule

`default_nettype wire

//--- design/bht_lookup_if.sv
`timescale 1ns/1ns
`default_nettype none

// prediction reads, one set of signals per fetch slot
interface bht_lookup_if;

    logic [bht_pkg::fetch_width-1:0][bht_pkg::index_bits-1:0]   rd_index;
    logic [bht_pkg::fetch_width-1:0][bht_pkg::history_bits-1:0] rd_history;
    bht_pkg::counter_e [bht_pkg::fetch_width-1:0]               rd_counter;

    // lookup side drives the index
    modport lookup (
        output rd_index,
        input  rd_history,
        input  rd_counter
    );

    // tables answer combinationally
    modport tables (
        input  rd_index,
        output rd_history,
        output rd_counter
    );

endinterface

`default_nettype wire

//--- design/bht_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared sizes and types of the local-history branch predictor
////////////////////////////////////////////////////////////////////////////

package bht_pkg;

    // instruction address and fetch group
    localparam int pc_width    = 32;
    localparam int fetch_width = 2;

    // table index comes from the word address bits 9..2
    localparam int index_lo   = 2;
    localparam int index_bits = 8;
    localparam int index_hi   = index_lo + index_bits - 1;

    // local history per entry
    localparam int history_bits = 8;
    localparam int bht_depth    = 256;

    // 2-bit saturating counter, upper half predicts taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_e;

endpackage

`default_nettype wire

//--- design/bht_predictor_top.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// two-wide local-history direction predictor
////////////////////////////////////////////////////////////////////////////

module bht_predictor_top (
    input  wire logic                                                   clk,
    input  wire logic                                                   rst,

    // fetch side, one address per slot
    input  wire logic [bht_pkg::fetch_width-1:0][bht_pkg::pc_width-1:0] fetch_pc,

    // resolved branch from dispatch
    input  wire logic                                                   update_en,
    input  wire logic [bht_pkg::pc_width-1:0]                           update_pc,
    input  wire logic                                                   update_taken,

    // guesses, valid one cycle after fetch_pc
    output logic [bht_pkg::fetch_width-1:0]                             taken
);

    bht_lookup_if lk_if ();
    bht_train_if  tr_if ();

    // fetch addresses into table reads
    bht_lookup lookup_i (
        .clk      (clk),
        .rst      (rst),
        .fetch_pc (fetch_pc),
        .taken    (taken),
        .lk       (lk_if.lookup)
    );

    // counter and history updates
    bht_train train_i (
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .tr           (tr_if.train)
    );

    // history and pattern state
    bht_tables tables_i (
        .clk (clk),
        .rst (rst),
        .lk  (lk_if.tables),
        .tr  (tr_if.tables)
    );

endmodule

`default_nettype wire

//--- design/bht_tables.sv
`timescale 1ns/1ns
`default_nettype none

module bht_tables (
    input  wire logic clk,
    input  wire logic rst,
    bht_lookup_if.tables lk,
    bht_train_if.tables  tr
);

    localparam int pht_rows = bht_pkg::bht_depth;
    localparam int pht_cols = 2 ** bht_pkg::history_bits;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // local history per address index
    logic [bht_pkg::history_bits-1:0] bht_mem [bht_pkg::bht_depth];

    // counters, row is history xor index, column is history
    bht_pkg::counter_e pht_mem [pht_rows][pht_cols];

    ////////////////////////////////////////////////////////////////////////////
    // prediction reads
    ////////////////////////////////////////////////////////////////////////////

    // history first, then the counter it points at
    always_comb begin
        for (int s = 0; s < bht_pkg::fetch_width; s++) begin
            lk.rd_history[s] = bht_mem[lk.rd_index[s]];
            lk.rd_counter[s] = pht_mem[lk.rd_history[s] ^ lk.rd_index[s]][lk.rd_history[s]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // update read
    ////////////////////////////////////////////////////////////////////////////

    logic [bht_pkg::index_bits-1:0] upd_row;

    assign tr.upd_history = bht_mem[tr.upd_index];
    assign upd_row        = tr.upd_history ^ tr.upd_index;
    assign tr.upd_counter = pht_mem[upd_row][tr.upd_history];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    // reads above still see the old contents this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            bht_mem <= '{default: '0};
            pht_mem <= '{default: '{default: bht_pkg::strong_not_taken}};
        end else if (tr.wr_en) begin
            bht_mem[tr.upd_index]            <= tr.wr_history;
            pht_mem[upd_row][tr.upd_history] <= tr.wr_counter;
        end
    end

endmodule

`default_nettype wire

//--- design/bht_train.sv
`timescale 1ns/1ns
`default_nettype none

module bht_train (
    input  wire logic                         update_en,
    input  wire logic [bht_pkg::pc_width-1:0] update_pc,
    input  wire logic                         update_taken,
    bht_train_if.train                        tr
);

    bht_pkg::counter_e counter_up;
    bht_pkg::counter_e counter_down;

    assign tr.upd_index = update_pc[bht_pkg::index_hi:bht_pkg::index_lo];
    assign tr.wr_en     = update_en;

    // newest outcome enters at bit 0, oldest falls off the top
    assign tr.wr_history = {tr.upd_history[bht_pkg::history_bits-2:0], update_taken};

    ////////////////////////////////////////////////////////////////////////////
    // saturating counter steps
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (tr.upd_counter)
            bht_pkg::strong_not_taken: counter_up = bht_pkg::weak_not_taken;
            bht_pkg::weak_not_taken:   counter_up = bht_pkg::weak_taken;
            bht_pkg::weak_taken:       counter_up = bht_pkg::strong_taken;
            bht_pkg::strong_taken:     counter_up = bht_pkg::strong_taken;
            default:                   counter_up = tr.upd_counter;
        endcase
    end

    always_comb begin
        unique case (tr.upd_counter)
            bht_pkg::strong_not_taken: counter_down = bht_pkg::strong_not_taken;
            bht_pkg::weak_not_taken:   counter_down = bht_pkg::strong_not_taken;
            bht_pkg::weak_taken:       counter_down = bht_pkg::weak_not_taken;
            bht_pkg::strong_taken:     counter_down = bht_pkg::weak_taken;
            default:                   counter_down = tr.upd_counter;
        endcase
    end

    // direction set by the resolved outcome
    assign tr.wr_counter = update_taken ? counter_up : counter_down;

endmodule

`default_nettype wire

//--- design/bht_train_if.sv
`timescale 1ns/1ns
`default_nettype none

// read-modify-write path for one resolved branch per cycle
interface bht_train_if;

    logic [bht_pkg::index_bits-1:0]   upd_index;
    logic [bht_pkg::history_bits-1:0] upd_history;
    bht_pkg::counter_e                upd_counter;
    logic                             wr_en;
    logic [bht_pkg::history_bits-1:0] wr_history;
    bht_pkg::counter_e                wr_counter;

    modport train (
        output upd_index,
        input  upd_history,
        input  upd_counter,
        output wr_en,
        output wr_history,
        output wr_counter
    );

    // write lands at the old-history position on the edge
    modport tables (
        input  upd_index,
        output upd_history,
        output upd_counter,
        input  wr_en,
        input  wr_history,
        input  wr_counter
    );

endinterface

`default_nettype wire

//--- files.f
design/bht_pkg.sv
design/bht_lookup_if.sv
design/bht_train_if.sv
design/bht_tables.sv
design/bht_lookup.sv
design/bht_train.sv
design/bht_predictor_top.sv
tb/tb_clock_gen.sv
tb/bht_predictor_properties.sv
tb/tb_bht_predictor.sv

//--- tb/bht_predictor_properties.sv
`timescale 1ns/1ns
`default_nettype none

module bht_predictor_properties (
    input wire logic                                clk,
    input wire logic                                rst,
    input wire logic                                update_en,
    input wire logic [bht_pkg::pc_width-1:0]        update_pc,
    input wire logic                                update_taken,
    input wire logic [bht_pkg::fetch_width-1:0]     taken
);

    int assert_failures = 0;

    // guesses come out of reset cleared
    taken_clear_after_reset: assert property (
        @(posedge clk) rst |=> (taken == '0)
    ) else begin
        $error("taken is not zero in the cycle after reset");
        assert_failures++;
    end

    taken_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(taken)
    ) else begin
        $error("taken has unknown bits");
        assert_failures++;
    end

    // a resolved branch must be fully driven
    update_known: assert property (
        @(posedge clk) disable iff (rst) update_en |-> !$isunknown({update_pc, update_taken})
    ) else begin
        $error("update inputs have unknown bits while update_en is high");
        assert_failures++;
    end

endmodule

bind bht_predictor_top bht_predictor_properties props_i (
    .clk          (clk),
    .rst          (rst),
    .update_en    (update_en),
    .update_pc    (update_pc),
    .update_taken (update_taken),
    .taken        (taken)
);

`default_nettype wire

//--- tb/tb_bht_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bht_predictor;

    localparam int random_cycles = 300;
    // clocks per test in the order they run
    localparam int test_cycles   = 6 + 14 + 17 + 16 + 17 + random_cycles + 1;
    localparam int clk_period_ns = 10;
    localparam int timeout_ns    = (test_cycles + 2 + 100) * clk_period_ns;
    localparam int pht_cols      = 2 ** bht_pkg::history_bits;

    logic                                                   clk;
    logic                                                   rst;
    logic [bht_pkg::fetch_width-1:0][bht_pkg::pc_width-1:0] fetch_pc;
    logic                                                   update_en;
    logic [bht_pkg::pc_width-1:0]                           update_pc;
    logic                                                   update_taken;
    logic [bht_pkg::fetch_width-1:0]                        taken;

    // reference model state
    logic [bht_pkg::history_bits-1:0] model_hist [bht_pkg::bht_depth];
    bht_pkg::counter_e                model_pht  [bht_pkg::bht_depth][pht_cols];

    // expected guess for the fetch the DUT samples next
    logic [bht_pkg::fetch_width-1:0] pending_taken;
    logic                            pending_valid;

    tb_clock_gen clock_i (
        .clk (clk),
        .rst (rst)
    );

    bht_predictor_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_pc     (fetch_pc),
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .taken        (taken)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [bht_pkg::index_bits-1:0] index_of(input logic [31:0] pc);
        return pc[bht_pkg::index_lo +: bht_pkg::index_bits];
    endfunction

    function automatic bht_pkg::counter_e model_counter(input logic [31:0] pc);
        logic [7:0] idx;
        logic [7:0] hist;
        idx  = index_of(pc);
        hist = model_hist[idx];
        return model_pht[hist ^ idx][hist];
    endfunction

    // upper half of the counter range means taken
    function automatic logic predict_one(input logic [31:0] pc);
        bht_pkg::counter_e ctr;
        ctr = model_counter(pc);
        return (ctr == bht_pkg::weak_taken) || (ctr == bht_pkg::strong_taken);
    endfunction

    task automatic train_model(input logic [31:0] pc, input logic outcome);
        logic [7:0]        idx;
        logic [7:0]        hist;
        bht_pkg::counter_e ctr;
        idx  = index_of(pc);
        hist = model_hist[idx];
        ctr  = model_pht[hist ^ idx][hist];
        if (outcome && (ctr != bht_pkg::strong_taken)) begin
            ctr = bht_pkg::counter_e'(ctr + 2'd1);
        end else if (!outcome && (ctr != bht_pkg::strong_not_taken)) begin
            ctr = bht_pkg::counter_e'(ctr - 2'd1);
        end
        model_pht[hist ^ idx][hist] = ctr;
        model_hist[idx] = {hist[6:0], outcome};
    endtask

    task automatic reset_model;
        for (int i = 0; i < bht_pkg::bht_depth; i++) begin
            model_hist[i] = '0;
            for (int j = 0; j < pht_cols; j++) begin
                model_pht[i][j] = bht_pkg::strong_not_taken;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_taken(input string name,
                                 input logic [bht_pkg::fetch_width-1:0] got,
                                 input logic [bht_pkg::fetch_width-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compare_counter(input string name, input bht_pkg::counter_e got,
                                   input bht_pkg::counter_e exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // counter the DUT would read for this address now
    function automatic bht_pkg::counter_e dut_counter(input logic [31:0] pc);
        logic [7:0] idx;
        logic [7:0] hist;
        idx  = index_of(pc);
        hist = dut_i.tables_i.bht_mem[idx];
        return dut_i.tables_i.pht_mem[hist ^ idx][hist];
    endfunction

    task automatic check_pending;
        if (pending_valid) begin
            compare_taken("taken", taken, pending_taken);
        end
        pending_valid = 1'b0;
    endtask

    // one clock of stimulus with the previous fetch checked at the falling edge
    task automatic step(input logic [31:0] pc0, input logic [31:0] pc1, input logic en,
                        input logic [31:0] upc, input logic outcome);
        @(posedge clk);
        fetch_pc[0]  <= pc0;
        fetch_pc[1]  <= pc1;
        update_en    <= en;
        update_pc    <= upc;
        update_taken <= outcome;
        @(negedge clk);
        check_pending();
        pending_taken = {predict_one(pc1), predict_one(pc0)};
        pending_valid = 1'b1;
        if (en) begin
            train_model(upc, outcome);
        end
    endtask

    task automatic flush;
        @(posedge clk);
        update_en <= 1'b0;
        @(negedge clk);
        check_pending();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_after_reset;
        for (int i = 0; i < 5; i++) begin
            step($urandom, $urandom, 1'b0, 32'h0, 1'b0);
        end
        flush();
        compare_taken("taken", taken, 2'b00);
    endtask

    task automatic test_train_taken;
        logic [31:0] pc;
        pc = 32'h0000_0104;
        for (int i = 0; i < 12; i++) begin
            step(pc, 32'h0000_2000, 1'b1, pc, 1'b1);
        end
        step(pc, pc, 1'b0, 32'h0, 1'b0);
        flush();
        compare_taken("taken", taken, 2'b11);
        compare_counter("pht_mem", dut_counter(pc), model_counter(pc));
        compare_counter("pht_mem", dut_counter(pc), bht_pkg::strong_taken);
    endtask

    // extra not-taken updates must hold at the bottom
    task automatic test_train_not_taken;
        logic [31:0] pc;
        pc = 32'h0000_0104;
        for (int i = 0; i < 16; i++) begin
            step(pc, pc, 1'b1, pc, 1'b0);
        end
        flush();
        compare_taken("taken", taken, 2'b00);
        compare_counter("pht_mem", dut_counter(pc), model_counter(pc));
        compare_counter("pht_mem", dut_counter(pc), bht_pkg::strong_not_taken);
    endtask

    task automatic test_two_slots;
        logic [31:0] pc_c;
        logic [31:0] pc_d;
        pc_c = 32'h0000_0208;
        pc_d = 32'h0000_030c;
        for (int i = 0; i < 12; i++) begin
            step(pc_d, pc_d, 1'b1, pc_c, 1'b1);
        end
        step(pc_c, pc_d, 1'b0, 32'h0, 1'b0);
        flush();
        compare_taken("taken", taken, 2'b01);
        // same bits 9..2, different upper bits
        step(32'habcd_0208, 32'h0000_0608, 1'b0, 32'h0, 1'b0);
        flush();
        compare_taken("taken", taken, 2'b11);
    endtask

    task automatic test_same_cycle;
        logic [31:0] pc;
        pc = 32'h0000_0010;
        for (int i = 0; i < 12; i++) begin
            step(pc, pc, 1'b1, pc, 1'b1);
        end
        flush();
        compare_taken("taken", taken, 2'b11);
        // fetch and not-taken update of the same address together
        step(pc, pc, 1'b1, pc, 1'b0);
        flush();
        compare_taken("taken", taken, 2'b11);
        step(pc, pc, 1'b0, 32'h0, 1'b0);
        flush();
        compare_taken("taken", taken, 2'b00);
    endtask

    // indices 0x90..0x93 with random upper address bits
    function automatic logic [31:0] random_pc;
        logic [31:0] r;
        r = $urandom;
        return {r[31:10], 6'b100100, r[1:0], 2'b00};
    endfunction

    task automatic test_random_mix;
        logic [31:0] r;
        for (int i = 0; i < random_cycles; i++) begin
            r = $urandom;
            step(random_pc(), random_pc(), r[0], random_pc(), r[1]);
        end
        flush();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #(timeout_ns);
        stop_on_error($sformatf("run did not finish within %0d ns, timed out", timeout_ns));
    end

    initial begin
        void'($urandom(32'h7ef7_84c4));
        fetch_pc      = '0;
        update_en     = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        pending_taken = '0;
        pending_valid = 1'b0;
        reset_model();
        wait (rst == 1'b0);
        test_after_reset();
        test_train_taken();
        test_train_not_taken();
        test_two_slots();
        test_same_cycle();
        test_random_mix();
        if (dut_i.props_i.assert_failures == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_on_error("one or more bound assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period_ns = 5;
    localparam int reset_cycles   = 2;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire
